/* chiplet_tx.f */
+incdir+include
source/chiplet_tx_pkg.sv
source/packet_mem.sv
source/crc32_accum.sv
source/tx_fsm.sv
source/flit_fifo.sv
source/link_serializer.sv
source/chiplet_tx_top.sv
sim/chiplet_tx_tb.sv

/* build.sh */
#!/bin/sh
# Compiles the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module chiplet_tx_tb -f chiplet_tx.f

status=0
output=$(./obj_dir/Vchiplet_tx_tb) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "simulation exit status: $status"
exit 1

/* sim/chiplet_tx_tb.sv */
`timescale 1ns/1ps

`include "chiplet_tx_cfg.svh"

module chiplet_tx_tb;

    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
    localparam int WAIT_LIMIT = 4000;

    typedef struct packed {
        logic [1:0]              slot;
        chiplet_tx_pkg::format_e fmt;
        logic [7:0]              len;
        logic [31:0]             base;
        logic [3:0]              node;
        logic                    rand_ready;
        logic                    pair;
        logic                    abort_first;
    } row_t;

    logic                  clk = 1'b0;
    logic                  n_rst;
    logic [`NUM_MSGS-1:0]  trigger_send;
    logic [`NODE_ID_W-1:0] node_id;
    logic                  mem_wen;
    logic [5:0]            mem_waddr;
    logic [31:0]           mem_wdata;
    logic                  link_ready = 1'b1;
    logic                  link_valid;
    logic [7:0]            link_data;
    logic                  pkt_sent;

    integer      seed = 85781;
    logic [31:0] rnd_word;
    logic        rand_ready;
    int          sent_count = 0;
    int          bytes_seen = 0;
    int          af_cycles = 0;
    int          exp_base, sent_base, af_base;
    logic [7:0]  expected_bytes [$];
    row_t        rows [5];
    logic [`NUM_MSGS-1:0] mask;

    chiplet_tx_top UUT (
        .clk(clk), .n_rst(n_rst), .trigger_send(trigger_send), .node_id(node_id),
        .mem_wen(mem_wen), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .link_ready(link_ready), .link_valid(link_valid), .link_data(link_data),
        .pkt_sent(pkt_sent)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        rnd_word = $random(seed);
        link_ready = rand_ready ? rnd_word[0] : 1'b1;
    end

    //////////////////////////////
    // Checks and reference model
    //////////////////////////////

    task automatic stop_with_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // MSB first, no reflection and no final inversion
    function automatic logic [31:0] crc_step(input logic [31:0] crc_in, input logic [31:0] word);
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int b = 31; b >= 0; b--) begin
            fb = c[31] ^ word[b];
            c = c << 1;
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] packet_word(input chiplet_tx_pkg::format_e fmt,
            input logic [7:0] len, input logic [1:0] slot, input logic [31:0] base, input int k);
        chiplet_tx_pkg::long_hdr_t hdr;
        hdr.format   = fmt;
        hdr.length   = len;
        hdr.dest     = {6'h2A, slot};
        hdr.reserved = '0;
        if (k == 0) begin
            return hdr;
        end
        return base + 32'(k) * 32'h1357_9BDF;
    endfunction

    task automatic push_flit_bytes(input logic [7:0] meta, input logic [31:0] payload);
        expected_bytes.push_back(meta);
        expected_bytes.push_back(payload[31:24]);
        expected_bytes.push_back(payload[23:16]);
        expected_bytes.push_back(payload[15:8]);
        expected_bytes.push_back(payload[7:0]);
    endtask

    task automatic write_word(input logic [5:0] addr, input logic [31:0] data);
        @(negedge clk);
        mem_wen = 1'b1;
        mem_waddr = addr;
        mem_wdata = data;
        @(negedge clk);
        mem_wen = 1'b0;
    endtask

    // Writes the packet into its slot and appends its bytes to the expected stream
    task automatic queue_packet(input logic [1:0] slot, input chiplet_tx_pkg::format_e fmt,
            input logic [7:0] len, input logic [31:0] base, input logic [3:0] node);
        logic [31:0] word;
        logic [31:0] crc;
        crc = '1;
        for (int k = 0; k < int'(len); k++) begin
            word = packet_word(fmt, len, slot, base, k);
            write_word(6'(slot * `MSG_STRIDE + k), word);
            push_flit_bytes({2'b00, slot, node}, word);
            crc = crc_step(crc, word);
        end
        if (fmt != chiplet_tx_pkg::FMT_SWITCH_CFG) begin
            push_flit_bytes({2'b00, slot, node}, crc);
        end
    endtask

    task automatic pulse_trigger(input logic [`NUM_MSGS-1:0] slots);
        @(negedge clk);
        trigger_send = slots;
        @(negedge clk);
        trigger_send = '0;
    endtask

    task automatic apply_reset(input logic [3:0] node);
        @(negedge clk);
        n_rst = 1'b0;
        node_id = node;
        expected_bytes.delete();
        exp_base = bytes_seen;
        sent_base = sent_count;
        af_base = af_cycles;
        repeat (8) @(negedge clk);
        n_rst = 1'b1;
    endtask

    task automatic wait_for_bytes(input int count);
        int cycles;
        cycles = 0;
        while (bytes_seen - exp_base < count) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("timeout while waiting for link bytes");
            end
        end
    endtask

    task automatic wait_for_drain(input int pkts);
        int cycles;
        cycles = 0;
        while (bytes_seen - exp_base < expected_bytes.size() || sent_count - sent_base < pkts) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_error("timeout while waiting for the packets to leave the link");
            end
        end
    endtask

    //////////////////////////////
    // Link capture
    //////////////////////////////

    always @(posedge clk) begin
        if (n_rst && pkt_sent) begin
            sent_count++;
        end
        if (n_rst && UUT.almost_full) begin
            af_cycles++;
        end
        if (link_valid) begin
            if (bytes_seen - exp_base >= expected_bytes.size()) begin
                stop_with_error("link_valid is high but no byte is expected");
            end
            check_value("link_data", 32'(link_data),
                        32'(expected_bytes[bytes_seen - exp_base]));
            bytes_seen++;
        end
    end

    initial begin
        n_rst = 1'b0;
        trigger_send = '0;
        node_id = '0;
        mem_wen = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        rand_ready = 1'b0;

        // slot, format, length, payload base, node, random ready, pair, reset mid-packet
        rows[0] = '{2'd1, chiplet_tx_pkg::FMT_LONG_READ, 8'd4, 32'h1000_0001, 4'h5,
                    1'b0, 1'b0, 1'b0};
        rows[1] = '{2'd2, chiplet_tx_pkg::FMT_SWITCH_CFG, 8'd3, 32'h2222_0002, 4'hA,
                    1'b0, 1'b0, 1'b0};
        rows[2] = '{2'd3, chiplet_tx_pkg::FMT_LONG_READ, 8'd5, 32'h3300_0003, 4'h3,
                    1'b0, 1'b1, 1'b0};
        rows[3] = '{2'd0, chiplet_tx_pkg::FMT_LONG_WRITE, 8'd16, 32'h4400_0004, 4'hC,
                    1'b1, 1'b0, 1'b0};
        rows[4] = '{2'd1, chiplet_tx_pkg::FMT_LONG_WRITE, 8'd6, 32'h5500_0005, 4'h7,
                    1'b0, 1'b0, 1'b1};

        for (int a = 0; a < `MEM_WORDS; a++) begin
            write_word(6'(a), 32'hC0DE_0000 ^ (32'(a) * 32'h0101_0101));
        end

        foreach (rows[i]) begin
            apply_reset(rows[i].node);
            rand_ready = rows[i].rand_ready;
            if (rows[i].abort_first) begin
                // This packet is cut off by the reset below
                queue_packet(2'd3, chiplet_tx_pkg::FMT_LONG_READ, 8'd12, 32'hDEAD_0000,
                             rows[i].node);
                pulse_trigger(`NUM_MSGS'(8));
                wait_for_bytes(12);
                apply_reset(rows[i].node);
            end
            queue_packet(rows[i].slot, rows[i].fmt, rows[i].len, rows[i].base, rows[i].node);
            mask = `NUM_MSGS'(1) << rows[i].slot;
            if (rows[i].pair) begin
                // Slot 0 goes out after the higher slot
                queue_packet(2'd0, rows[i].fmt, rows[i].len, ~rows[i].base, rows[i].node);
                mask = mask | `NUM_MSGS'(1);
            end
            pulse_trigger(mask);
            wait_for_drain(rows[i].pair ? 2 : 1);
            repeat (20) @(negedge clk);
            check_value("pkt_sent count", 32'(sent_count - sent_base), rows[i].pair ? 2 : 1);
            if (rows[i].rand_ready) begin
                check_value("almost_full reached", 32'(af_cycles > af_base), 32'd1);
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* source/chiplet_tx_top.sv */
`timescale 1ns/1ps

`include "chiplet_tx_cfg.svh"

module chiplet_tx_top (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic [`NUM_MSGS-1:0]  trigger_send,
    input  logic [`NODE_ID_W-1:0] node_id,
    input  logic                  mem_wen,
    input  logic [5:0]            mem_waddr,
    input  logic [31:0]           mem_wdata,
    input  logic                  link_ready,
    output logic                  link_valid,
    output logic [7:0]            link_data,
    output logic                  pkt_sent
);

    logic [5:0]            rd_addr;
    logic [31:0]           rd_data;
    logic                  push, pop, empty, almost_full;
    chiplet_tx_pkg::flit_t push_flit, pop_flit;

    packet_mem mem (
        .clk(clk), .wen(mem_wen), .waddr(mem_waddr), .wdata(mem_wdata),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    tx_fsm producer (
        .clk(clk), .n_rst(n_rst), .trigger_send(trigger_send), .node_id(node_id),
        .rd_addr(rd_addr), .rd_data(rd_data), .almost_full(almost_full),
        .push(push), .push_flit(push_flit), .pkt_sent(pkt_sent)
    );

    flit_fifo buffer (
        .clk(clk), .n_rst(n_rst), .push(push), .push_flit(push_flit),
        .pop(pop), .pop_flit(pop_flit), .empty(empty), .almost_full(almost_full)
    );

    link_serializer consumer (
        .clk(clk), .n_rst(n_rst), .pop(pop), .pop_flit(pop_flit), .empty(empty),
        .link_ready(link_ready), .link_valid(link_valid), .link_data(link_data)
    );

endmodule

/* source/link_serializer.sv */
`timescale 1ns/1ps

module link_serializer (
    input  logic                  clk,
    input  logic                  n_rst,
    output logic                  pop,
    input  chiplet_tx_pkg::flit_t pop_flit,
    input  logic                  empty,
    input  logic                  link_ready,
    output logic                  link_valid,
    output logic [7:0]            link_data
);

    chiplet_tx_pkg::ser_state_e state;
    chiplet_tx_pkg::flit_t      cur_flit;
    logic [2:0]                 byte_idx;

    assign pop        = (state == chiplet_tx_pkg::SER_IDLE) && !empty;
    assign link_valid = (state == chiplet_tx_pkg::SER_SHIFT) && link_ready;

    //////////////////////////////
    // Byte select
    //////////////////////////////

    // Metadata goes first, then the payload from its top byte down
    always_comb begin
        case (byte_idx)
            3'd0:    link_data = cur_flit.metadata;
            3'd1:    link_data = cur_flit.payload[31:24];
            3'd2:    link_data = cur_flit.payload[23:16];
            3'd3:    link_data = cur_flit.payload[15:8];
            default: link_data = cur_flit.payload[7:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_flit <= pop_flit;
        end
    end

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= chiplet_tx_pkg::SER_IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                chiplet_tx_pkg::SER_IDLE: begin
                    if (pop) begin
                        state    <= chiplet_tx_pkg::SER_SHIFT;
                        byte_idx <= '0;
                    end
                end
                chiplet_tx_pkg::SER_SHIFT: begin
                    // A byte only advances when the link takes it
                    if (link_ready) begin
                        if (byte_idx == 3'd4) begin
                            state <= chiplet_tx_pkg::SER_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 3'd1;
                        end
                    end
                end
                default: state <= chiplet_tx_pkg::SER_IDLE;
            endcase
        end
    end

endmodule

/* source/flit_fifo.sv */
`timescale 1ns/1ps

`include "chiplet_tx_cfg.svh"

module flit_fifo (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  push,
    input  chiplet_tx_pkg::flit_t push_flit,
    input  logic                  pop,
    output chiplet_tx_pkg::flit_t pop_flit,
    output logic                  empty,
    output logic                  almost_full
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] AF_LEVEL = CNT_W'(3 * `FIFO_DEPTH / 4);

    chiplet_tx_pkg::flit_t buffer [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push, do_pop;

    assign do_push = push && (count != CNT_W'(`FIFO_DEPTH));
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // Head entry is visible before the pop so the consumer can take it on the same edge
    assign pop_flit    = buffer[rd_ptr];
    assign empty       = (count == '0);
    assign almost_full = (count >= AF_LEVEL);

endmodule

/* source/tx_fsm.sv */
`timescale 1ns/1ps

`include "chiplet_tx_cfg.svh"

module tx_fsm (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic [`NUM_MSGS-1:0]   trigger_send,
    input  logic [`NODE_ID_W-1:0]  node_id,
    output logic [5:0]             rd_addr,
    input  logic [31:0]            rd_data,
    input  logic                   almost_full,
    output logic                   push,
    output chiplet_tx_pkg::flit_t  push_flit,
    output logic                   pkt_sent
);

    chiplet_tx_pkg::tx_state_e state, next_state;
    chiplet_tx_pkg::long_hdr_t hdr;
    chiplet_tx_pkg::format_e   cur_fmt;
    chiplet_tx_pkg::pkt_id_t   cur_id, sel_id;

    logic [`NUM_MSGS-1:0] pending, accept_mask;
    logic [7:0]           cur_len, word_cnt;
    logic                 last_word, crc_clear, crc_update;
    logic [31:0]          crc;

    crc32_accum crc_gen (
        .clk(clk),
        .n_rst(n_rst),
        .clear(crc_clear),
        .update(crc_update),
        .word(rd_data),
        .crc(crc)
    );

    //////////////////////////////
    // Slot arbitration
    //////////////////////////////

    // Higher slots win, so the last pending bit seen is kept
    always_comb begin
        sel_id = '0;
        for (int i = 0; i < `NUM_MSGS; i++) begin
            if (pending[i]) begin
                sel_id = chiplet_tx_pkg::pkt_id_t'(i);
            end
        end
    end

    assign accept_mask = (state == chiplet_tx_pkg::TX_IDLE && |pending) ?
                         (`NUM_MSGS'(1) << sel_id) : '0;

    //////////////////////////////
    // Control registers
    //////////////////////////////

    assign hdr = chiplet_tx_pkg::long_hdr_t'(rd_data);
    assign last_word = ({1'b0, word_cnt} + 9'd1) >= {1'b0, cur_len};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= chiplet_tx_pkg::TX_IDLE;
            pending  <= '0;
            cur_id   <= '0;
            cur_fmt  <= chiplet_tx_pkg::FMT_LONG_READ;
            cur_len  <= '0;
            word_cnt <= '0;
        end else begin
            state   <= next_state;
            pending <= (pending & ~accept_mask) | trigger_send;
            // The word counter starts over here so the header is read in LOAD_HDR
            if (|accept_mask) begin
                cur_id   <= sel_id;
                word_cnt <= '0;
            end
            if (state == chiplet_tx_pkg::TX_LOAD_HDR) begin
                cur_fmt  <= hdr.format;
                cur_len  <= hdr.length;
            end else if (crc_update) begin
                word_cnt <= word_cnt + 8'd1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            chiplet_tx_pkg::TX_IDLE: begin
                if (|pending) begin
                    next_state = chiplet_tx_pkg::TX_LOAD_HDR;
                end
            end
            chiplet_tx_pkg::TX_LOAD_HDR: next_state = chiplet_tx_pkg::TX_SEND_PKT;
            chiplet_tx_pkg::TX_SEND_PKT: begin
                if (push && last_word) begin
                    if (cur_fmt == chiplet_tx_pkg::FMT_SWITCH_CFG) begin
                        next_state = chiplet_tx_pkg::TX_IDLE;
                    end else begin
                        next_state = chiplet_tx_pkg::TX_CRC;
                    end
                end
            end
            chiplet_tx_pkg::TX_CRC: begin
                if (push) begin
                    next_state = chiplet_tx_pkg::TX_IDLE;
                end
            end
            default: next_state = chiplet_tx_pkg::TX_IDLE;
        endcase
    end

    //////////////////////////////
    // Flit output
    //////////////////////////////

    assign rd_addr = 6'(cur_id * `MSG_STRIDE + word_cnt);

    assign push = (state == chiplet_tx_pkg::TX_SEND_PKT || state == chiplet_tx_pkg::TX_CRC)
                  && !almost_full;

    assign crc_clear  = (state == chiplet_tx_pkg::TX_LOAD_HDR);
    assign crc_update = (state == chiplet_tx_pkg::TX_SEND_PKT) && push;

    assign push_flit.metadata.vc  = 2'd0;
    assign push_flit.metadata.id  = cur_id;
    assign push_flit.metadata.req = node_id;
    assign push_flit.payload = (state == chiplet_tx_pkg::TX_CRC) ? crc : rd_data;

    // A switch configuration packet ends on its last word, the others on the CRC flit
    assign pkt_sent = push && ((state == chiplet_tx_pkg::TX_CRC) ||
                               (last_word && cur_fmt == chiplet_tx_pkg::FMT_SWITCH_CFG));

endmodule

/* source/crc32_accum.sv */
`timescale 1ns/1ps

module crc32_accum (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        clear,
    input  logic        update,
    input  logic [31:0] word,
    output logic [31:0] crc
);

    localparam logic [31:0] POLY = 32'h04C1_1DB7;

    logic [31:0] crc_reg;
    logic [31:0] crc_next;

    // Shift the word in from bit 31 down, one polynomial step per bit
    always_comb begin
        crc_next = crc_reg;
        for (int i = 31; i >= 0; i--) begin
            if (crc_next[31] ^ word[i]) begin
                crc_next = {crc_next[30:0], 1'b0} ^ POLY;
            end else begin
                crc_next = {crc_next[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_reg <= '1;
        end else if (clear) begin
            crc_reg <= '1;
        end else if (update) begin
            crc_reg <= crc_next;
        end
    end

    assign crc = crc_reg;

endmodule

/* source/packet_mem.sv */
`timescale 1ns/1ps

`include "chiplet_tx_cfg.svh"

module packet_mem (
    input  logic        clk,
    input  logic        wen,
    input  logic [5:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [5:0]  rd_addr,
    output logic [31:0] rd_data
);

    logic [31:0] mem [`MEM_WORDS];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // The producer sees the word in the same cycle it drives the address
    assign rd_data = mem[rd_addr];

endmodule

/* source/chiplet_tx_pkg.sv */
`include "chiplet_tx_cfg.svh"

package chiplet_tx_pkg;

    typedef enum logic [3:0] {
        FMT_LONG_READ  = 4'h0,
        FMT_LONG_WRITE = 4'h1,
        FMT_SWITCH_CFG = 4'h2
    } format_e;

    // Header word, length counts every word of the packet including this one
    typedef struct packed {
        format_e     format;
        logic [7:0]  length;
        logic [7:0]  dest;
        logic [11:0] reserved;
    } long_hdr_t;

    typedef logic [$clog2(`NUM_MSGS)-1:0] pkt_id_t;

    typedef struct packed {
        logic [1:0]            vc;
        pkt_id_t               id;
        logic [`NODE_ID_W-1:0] req;
    } flit_meta_t;

    typedef struct packed {
        flit_meta_t  metadata;
        logic [31:0] payload;
    } flit_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_LOAD_HDR, TX_SEND_PKT, TX_CRC
    } tx_state_e;

    typedef enum logic {
        SER_IDLE, SER_SHIFT
    } ser_state_e;

endpackage

/* include/chiplet_tx_cfg.svh */
`ifndef CHIPLET_TX_CFG_SVH
`define CHIPLET_TX_CFG_SVH

// Number of message slots that software can trigger
`define NUM_MSGS 4

// Words reserved for each slot, slot i starts at i * MSG_STRIDE
`define MSG_STRIDE 16

// Packet memory depth in 32-bit words
`define MEM_WORDS 64

// Flit buffer entries
`define FIFO_DEPTH 8

`define NODE_ID_W 4

`endif
